// ==== logic/rv_pkg.sv ====
/* RV32I pipeline types */
package rv_pkg;

  localparam int xlen_c = 32;  // Data path width

  typedef logic [4:0]        reg_addr_t;
  typedef logic [xlen_c-1:0] word_t;

  // ================================================
  // Encodings
  // ================================================
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,  // LW only
    OP_STORE  = 7'b0100011,  // SW only
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_PC4 = 2'd2  // Link value for JAL/JALR
  } wb_sel_e;

  typedef enum logic [1:0] {
    FWD_NONE  = 2'd0,
    FWD_EXMEM = 2'd1,
    FWD_MEMWB = 2'd2
  } fwd_sel_e;

  // Operand A source, PC for AUIPC/JAL/branches, zero for LUI
  typedef enum logic [1:0] {
    OPA_REG  = 2'd0,
    OPA_PC   = 2'd1,
    OPA_ZERO = 2'd2
  } opa_sel_e;

  // ================================================
  // Stage records
  // ================================================
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
  } ifid_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     rs1_val;
    word_t     rs2_val;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    alu_op_e   alu_op;
    logic      alu_src;    // Operand B is the immediate
    opa_sel_e  opa_sel;
    logic      branch;
    logic      jump;
    logic      jalr;
    logic [2:0] funct3;    // Branch condition
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    wb_sel_e   wb_sel;
  } idex_t;

  typedef struct packed {
    logic      valid;
    word_t     alu_result;
    word_t     store_data;
    word_t     pc_plus_4;
    reg_addr_t rd;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    wb_sel_e   wb_sel;
  } exmem_t;

  typedef struct packed {
    logic      valid;
    word_t     alu_result;
    word_t     load_data;
    word_t     pc_plus_4;
    reg_addr_t rd;
    logic      reg_write;
    wb_sel_e   wb_sel;
  } memwb_t;

  // Register write, also the observable retirement
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    word_t     data;
  } retire_t;

  typedef struct packed {
    logic  taken;
    word_t target;
  } redirect_t;

endpackage

// ==== logic/fetch_stage.sv ====
/* Instruction fetch */
`timescale 1ns/1ps

module fetch_stage import rv_pkg::*; #(
  parameter word_t RESET_VECTOR = '0
) (
  input  logic      clk,
  input  logic      reset_n,
  input  logic      stall,
  input  redirect_t redirect,
  output word_t     imem_addr,
  input  word_t     imem_data,
  output ifid_t     ifid
);

  word_t pc;
  word_t pc_next;

  // Redirect from EX wins, stall freezes PC
  assign pc_next = redirect.taken ? redirect.target :
                   stall          ? pc :
                                    pc + word_t'(4);

  assign imem_addr = pc;  // Data comes back same cycle

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pc <= RESET_VECTOR;
    end else begin
      pc <= pc_next;
    end
  end

  // IF/ID register
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ifid <= '0;
    end else if (redirect.taken) begin
      ifid.valid <= 1'b0;       // Wrong-path fetch dropped
    end else if (!stall) begin
      ifid.valid <= 1'b1;
      ifid.pc    <= pc;
      ifid.instr <= imem_data;
    end
  end

  // Targets from EX must keep fetch on word boundaries
  pc_word_aligned: assert property (@(posedge clk) disable iff (!reset_n) pc[1:0] == 2'b00)
    else $error("PC not word aligned: %h", pc);

endmodule

// ==== logic/decode_stage.sv ====
/* Instruction decode */
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  ifid_t     ifid,
  input  logic      stall,
  input  logic      bubble,
  input  redirect_t redirect,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  input  word_t     rs1_data,
  input  word_t     rs2_data,
  output idex_t     idex
);

  word_t      instr;
  logic [2:0] funct3;
  logic       alt;    // Bit 30, selects SUB/SRA
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  idex_t      dec;

  assign instr    = ifid.instr;
  assign funct3   = instr[14:12];
  assign alt      = instr[30];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];

  // ================================================
  // Immediates
  // ================================================
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // ALU operation from funct3
  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic sub_sra);
    alu_op_e op;
    case (f3)
      3'b000:  op = sub_sra ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = sub_sra ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // ================================================
  // Control
  // ================================================
  always_comb begin
    dec         = '0;    // Unknown opcodes fall out as no-ops
    dec.valid   = ifid.valid;
    dec.pc      = ifid.pc;
    dec.rs1_val = rs1_data;
    dec.rs2_val = rs2_data;
    dec.rs1     = rs1_addr;
    dec.rs2     = rs2_addr;
    dec.rd      = instr[11:7];
    dec.funct3  = funct3;
    dec.alu_op  = ALU_ADD;
    dec.opa_sel = OPA_REG;
    dec.wb_sel  = WB_ALU;
    case (instr[6:0])
      OP_LUI: begin
        dec.imm       = imm_u;
        dec.alu_src   = 1'b1;
        dec.opa_sel   = OPA_ZERO;   // 0 + imm
        dec.reg_write = 1'b1;
      end
      OP_AUIPC: begin
        dec.imm       = imm_u;
        dec.alu_src   = 1'b1;
        dec.opa_sel   = OPA_PC;
        dec.reg_write = 1'b1;
      end
      OP_JAL: begin
        dec.imm       = imm_j;
        dec.alu_src   = 1'b1;
        dec.opa_sel   = OPA_PC;     // ALU builds the target
        dec.jump      = 1'b1;
        dec.reg_write = 1'b1;
        dec.wb_sel    = WB_PC4;
      end
      OP_JALR: begin
        dec.imm       = imm_i;
        dec.alu_src   = 1'b1;
        dec.jump      = 1'b1;
        dec.jalr      = 1'b1;
        dec.reg_write = 1'b1;
        dec.wb_sel    = WB_PC4;
      end
      OP_BRANCH: begin
        dec.imm     = imm_b;
        dec.alu_src = 1'b1;
        dec.opa_sel = OPA_PC;
        dec.branch  = 1'b1;
      end
      OP_LOAD: begin
        dec.imm       = imm_i;
        dec.alu_src   = 1'b1;
        dec.mem_read  = 1'b1;
        dec.reg_write = 1'b1;
        dec.wb_sel    = WB_MEM;
      end
      OP_STORE: begin
        dec.imm       = imm_s;
        dec.alu_src   = 1'b1;
        dec.mem_write = 1'b1;
      end
      OP_IMM: begin
        dec.imm       = imm_i;
        dec.alu_src   = 1'b1;
        dec.alu_op    = alu_from_funct3(funct3, (funct3 == 3'b101) && alt);  // Only SRAI
        dec.reg_write = 1'b1;
      end
      OP_REG: begin
        dec.alu_op    = alu_from_funct3(funct3, alt);
        dec.reg_write = 1'b1;
      end
      default: ;
    endcase
  end

  // ID/EX register
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      idex <= '0;
    end else if (redirect.taken || bubble) begin
      idex.valid <= 1'b0;   // Flush or load-use bubble
    end else if (!stall) begin
      idex <= dec;
    end
  end

endmodule

// ==== logic/register_file.sv ====
/* Integer register file */
`timescale 1ns/1ps

module register_file import rv_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  output word_t     rs1_data,
  output word_t     rs2_data,
  input  retire_t   wb
);

  word_t regs [1:31];  // x0 not stored
  logic  hit1;
  logic  hit2;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.valid && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Write in the same cycle as a read is passed straight through
  assign hit1 = wb.valid && (wb.rd == rs1_addr);
  assign hit2 = wb.valid && (wb.rd == rs2_addr);

  assign rs1_data = (rs1_addr == '0) ? '0 :
                    hit1             ? wb.data : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 :
                    hit2             ? wb.data : regs[rs2_addr];

endmodule

// ==== logic/hazard_unit.sv ====
/* Hazard detection and forwarding */
`timescale 1ns/1ps

module hazard_unit import rv_pkg::*; (
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  idex_t     idex,
  input  exmem_t    exmem,
  input  memwb_t    memwb,
  output logic      stall,
  output logic      bubble,
  output fwd_sel_e  fwd_a,
  output fwd_sel_e  fwd_b
);

  logic load_use;

  // Load in EX feeding the instruction in decode
  assign load_use = idex.valid && idex.mem_read && (idex.rd != '0) &&
                    ((idex.rd == rs1_addr) || (idex.rd == rs2_addr));

  assign stall  = load_use;  // Hold PC and IF/ID
  assign bubble = load_use;  // Empty slot into ID/EX

  // Youngest producer wins, x0 never forwards
  function automatic fwd_sel_e pick(input reg_addr_t src);
    fwd_sel_e sel;
    sel = FWD_NONE;
    if (exmem.valid && exmem.reg_write && (exmem.rd != '0) && (exmem.rd == src)) begin
      sel = FWD_EXMEM;
    end else if (memwb.valid && memwb.reg_write && (memwb.rd != '0) && (memwb.rd == src)) begin
      sel = FWD_MEMWB;
    end
    return sel;
  endfunction

  always_comb begin
    fwd_a = pick(idex.rs1);
    fwd_b = pick(idex.rs2);
  end

endmodule

// ==== logic/execute_stage.sv ====
/* Execute stage */
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  idex_t     idex,
  input  fwd_sel_e  fwd_a,
  input  fwd_sel_e  fwd_b,
  input  retire_t   wb,
  output redirect_t redirect,
  output exmem_t    exmem
);

  word_t      rs1_fwd;
  word_t      rs2_fwd;
  word_t      op_a;
  word_t      op_b;
  word_t      alu_y;
  word_t      pc_plus_4;
  logic [4:0] shamt;
  logic       cond;    // Branch condition met

  // ================================================
  // Forwarding
  // ================================================
  always_comb begin
    case (fwd_a)
      FWD_EXMEM: rs1_fwd = exmem.alu_result;
      FWD_MEMWB: rs1_fwd = wb.data;
      default:   rs1_fwd = idex.rs1_val;
    endcase
    case (fwd_b)
      FWD_EXMEM: rs2_fwd = exmem.alu_result;
      FWD_MEMWB: rs2_fwd = wb.data;
      default:   rs2_fwd = idex.rs2_val;
    endcase
  end

  always_comb begin
    case (idex.opa_sel)
      OPA_PC:   op_a = idex.pc;
      OPA_ZERO: op_a = '0;
      default:  op_a = rs1_fwd;
    endcase
  end

  assign op_b  = idex.alu_src ? idex.imm : rs2_fwd;
  assign shamt = op_b[4:0];

  // ================================================
  // ALU
  // ================================================
  always_comb begin
    case (idex.alu_op)
      ALU_ADD:  alu_y = op_a + op_b;
      ALU_SUB:  alu_y = op_a - op_b;
      ALU_SLL:  alu_y = op_a << shamt;
      ALU_SLT:  alu_y = {{(xlen_c-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_y = {{(xlen_c-1){1'b0}}, op_a < op_b};
      ALU_XOR:  alu_y = op_a ^ op_b;
      ALU_SRL:  alu_y = op_a >> shamt;
      ALU_SRA:  alu_y = word_t'($signed(op_a) >>> shamt);
      ALU_OR:   alu_y = op_a | op_b;
      ALU_AND:  alu_y = op_a & op_b;
      default:  alu_y = '0;
    endcase
  end

  // Branch compare on forwarded sources
  always_comb begin
    case (idex.funct3)
      3'b000:  cond = (rs1_fwd == rs2_fwd);                   // BEQ
      3'b001:  cond = (rs1_fwd != rs2_fwd);                   // BNE
      3'b100:  cond = ($signed(rs1_fwd) < $signed(rs2_fwd));  // BLT
      3'b101:  cond = ($signed(rs1_fwd) >= $signed(rs2_fwd)); // BGE
      3'b110:  cond = (rs1_fwd < rs2_fwd);                    // BLTU
      3'b111:  cond = (rs1_fwd >= rs2_fwd);                   // BGEU
      default: cond = 1'b0;
    endcase
  end

  assign pc_plus_4 = idex.pc + word_t'(4);

  // ALU already holds PC+imm or rs1+imm
  assign redirect.taken  = idex.valid && (idex.jump || (idex.branch && cond));
  assign redirect.target = idex.jalr ? {alu_y[xlen_c-1:1], 1'b0} : alu_y;

  // EX/MEM register
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      exmem <= '0;
    end else begin
      exmem.valid      <= idex.valid;
      exmem.alu_result <= idex.jump ? pc_plus_4 : alu_y;  // Link value forwards correctly
      exmem.store_data <= rs2_fwd;
      exmem.pc_plus_4  <= pc_plus_4;
      exmem.rd         <= idex.rd;
      exmem.mem_read   <= idex.mem_read;
      exmem.mem_write  <= idex.mem_write;
      exmem.reg_write  <= idex.reg_write;
      exmem.wb_sel     <= idex.wb_sel;
    end
  end

  // Load-use bubble keeps a consumer off the EX/MEM load address
  no_load_forward: assert property (@(posedge clk) disable iff (!reset_n)
    idex.valid && exmem.valid && exmem.mem_read |->
      (fwd_a != FWD_EXMEM) && (fwd_b != FWD_EXMEM))
    else $error("Load address forwarded from EX/MEM as data");

endmodule

// ==== logic/memory_stage.sv ====
/* Data memory and write-back */
`timescale 1ns/1ps

module memory_stage import rv_pkg::*; #(
  parameter int DMEM_WORDS = 1024
) (
  input  logic    clk,
  input  logic    reset_n,
  input  exmem_t  exmem,
  output retire_t retire
);

  localparam int aw_c = $clog2(DMEM_WORDS);

  word_t           dmem [DMEM_WORDS];
  logic [aw_c-1:0] index;
  memwb_t          memwb;
  word_t           wb_data;

  assign index = exmem.alu_result[aw_c+1:2];  // Word index

  // Store
  always_ff @(posedge clk) begin
    if (exmem.valid && exmem.mem_write) begin
      dmem[index] <= exmem.store_data;
    end
  end

  // MEM/WB register, load data read combinationally
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      memwb <= '0;
    end else begin
      memwb.valid      <= exmem.valid;
      memwb.alu_result <= exmem.alu_result;
      memwb.load_data  <= dmem[index];
      memwb.pc_plus_4  <= exmem.pc_plus_4;
      memwb.rd         <= exmem.rd;
      memwb.reg_write  <= exmem.reg_write;
      memwb.wb_sel     <= exmem.wb_sel;
    end
  end

  // ================================================
  // Write-back
  // ================================================
  always_comb begin
    case (memwb.wb_sel)
      WB_MEM:  wb_data = memwb.load_data;
      WB_PC4:  wb_data = memwb.pc_plus_4;
      default: wb_data = memwb.alu_result;
    endcase
  end

  assign retire.valid = memwb.valid && memwb.reg_write && (memwb.rd != '0);
  assign retire.rd    = memwb.rd;
  assign retire.data  = wb_data;

  // Address comes from the EX adder, LW/SW only
  mem_word_aligned: assert property (@(posedge clk) disable iff (!reset_n)
    exmem.valid && (exmem.mem_read || exmem.mem_write) |-> exmem.alu_result[1:0] == 2'b00)
    else $error("Misaligned data access at %h", exmem.alu_result);

endmodule

// ==== logic/rv_core.sv ====
/* Five-stage RV32I core */
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
  parameter word_t RESET_VECTOR = '0,
  parameter int    DMEM_WORDS   = 1024
) (
  input  logic    clk,
  input  logic    reset_n,
  output word_t   imem_addr,
  input  word_t   imem_data,
  output retire_t retire
);

  ifid_t     ifid;
  idex_t     idex;
  exmem_t    exmem;
  memwb_t    memwb_view;
  redirect_t redirect;
  logic      stall;
  logic      bubble;
  fwd_sel_e  fwd_a;
  fwd_sel_e  fwd_b;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_data;
  word_t     rs2_data;

  // MEM/WB producer seen by hazard logic, rebuilt from write-back
  always_comb begin
    memwb_view           = '0;
    memwb_view.valid     = retire.valid;
    memwb_view.reg_write = retire.valid;
    memwb_view.rd        = retire.rd;
  end

  // ================================================
  // Stages
  // ================================================
  fetch_stage #(.RESET_VECTOR(RESET_VECTOR)) fetch_inst (
    .clk(clk), .reset_n(reset_n), .stall(stall), .redirect(redirect),
    .imem_addr(imem_addr), .imem_data(imem_data), .ifid(ifid)
  );

  decode_stage decode_inst (
    .clk(clk), .reset_n(reset_n), .ifid(ifid), .stall(stall), .bubble(bubble),
    .redirect(redirect), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .idex(idex)
  );

  register_file regfile_inst (
    .clk(clk), .reset_n(reset_n), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .wb(retire)
  );

  hazard_unit hazard_inst (
    .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .idex(idex), .exmem(exmem),
    .memwb(memwb_view), .stall(stall), .bubble(bubble), .fwd_a(fwd_a), .fwd_b(fwd_b)
  );

  execute_stage execute_inst (
    .clk(clk), .reset_n(reset_n), .idex(idex), .fwd_a(fwd_a), .fwd_b(fwd_b),
    .wb(retire), .redirect(redirect), .exmem(exmem)
  );

  memory_stage #(.DMEM_WORDS(DMEM_WORDS)) memory_inst (
    .clk(clk), .reset_n(reset_n), .exmem(exmem), .retire(retire)  // Retire doubles as WB
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
/* Clock and reset */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic reset_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release lands just after a rising edge
  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #2 reset_n = 1'b1;
  end

endmodule

// ==== verification/rv_core_tb.sv ====
/* Pipeline core testbench */
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();

  localparam word_t reset_vector_c = 32'h0000_0000;
  localparam int    dmem_words_c   = 256;
  localparam int    golden_depth_c = 128;           // Header, program and records
  localparam word_t self_jump_c    = 32'h0000_006f;  // Loops in place past the end

  typedef logic [$clog2(golden_depth_c)-1:0] slot_t;

  logic        clk;
  logic        reset_n;
  word_t       imem_addr;
  word_t       imem_data;
  retire_t     retire;

  logic [39:0] golden [golden_depth_c];  // Record layout {rd byte, value}
  int          prog_len;
  int          rec_count;
  int          rec_idx;      // Next expected retirement
  int          cycle_count;
  int          cycle_limit;

  tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(16)) clock_gen_inst (
    .clk(clk), .reset_n(reset_n)
  );

  rv_core #(.RESET_VECTOR(reset_vector_c), .DMEM_WORDS(dmem_words_c)) rv_core_inst (
    .clk(clk), .reset_n(reset_n), .imem_addr(imem_addr), .imem_data(imem_data),
    .retire(retire)
  );

  // ================================================
  // Instruction memory model
  // ================================================
  function automatic word_t fetch_word(input word_t addr);
    word_t word_index;
    word_index = (addr - reset_vector_c) >> 2;
    if (word_index >= word_t'(prog_len)) begin
      return self_jump_c;  // Beyond the program
    end
    return golden[slot_t'(word_index + 32'd2)][31:0];  // Program starts at word 2
  endfunction

  // Fetch data follows the PC shortly after each edge
  initial begin
    imem_data = '0;
    forever begin
      @(posedge clk);
      #2;
      imem_data = fetch_word(imem_addr);
    end
  end

  // ================================================
  // Checking
  // ================================================
  task automatic check_equal(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t: %s got %h expected %h", $time, what, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Next record in program order
  task automatic check_retire();
    logic [39:0] rec;
    rec = golden[slot_t'(2 + prog_len + rec_idx)];
    check_equal(word_t'(retire.rd), word_t'(rec[39:32]),
                $sformatf("record %0d destination", rec_idx));
    check_equal(retire.data, rec[31:0],
                $sformatf("record %0d value of x%0d", rec_idx, retire.rd));
    rec_idx++;
  endtask

  initial begin
    rec_idx     = 0;
    cycle_count = 0;
    $readmemh("verification/program_golden.hex", golden);
    prog_len    = int'(golden[0][31:0]);
    rec_count   = int'(golden[1][31:0]);
    cycle_limit = prog_len * 8 + 100;  // Stalls and flushes fit well inside

    @(posedge reset_n);
    // Core leaves reset at the reset vector with nothing retiring
    check_equal(imem_addr, reset_vector_c, "PC after reset");
    check_equal(word_t'(retire.valid), 32'd0, "retire valid after reset");

    // Retire port settles after the rising edge, sampled mid-cycle
    while ((rec_idx < rec_count) && (cycle_count < cycle_limit)) begin
      @(negedge clk);
      cycle_count++;
      if (retire.valid) begin
        check_retire();
      end
    end

    if (rec_idx == rec_count) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("Retirements stopped after %0d of %0d records in %0d cycles",
               rec_idx, rec_count, cycle_count);
      $display("*** FAILED ***");
      $fatal(1, "Timeout waiting for retirements");
    end
  end

endmodule

// ==== verification/program_golden.hex ====
// Word 0 program length and word 1 record count, then the program words
// Then one record per retirement with rd in the top byte and the value below
21 15
// ALU ops, LUI and AUIPC with every forwarding path
00500093 FFD08113 402081B3 0030C233  // 0x00 addi x1 / addi x2 / sub x3 / xor x4
123452B7 00001317 0042E3B3 FF000413  // 0x10 lui x5 / auipc x6 / or x7 / addi x8
40245493 01C45513 001425B3 00143633  // 0x20 srai x9 / srli x10 / slt x11 / sltu x12
// Store, load with its consumer right behind, x0 write and read
00A3F6B3 00702423 00802703 001707B3  // 0x30 and x13 / sw x7 / lw x14 / add x15
00708013 00100833 00208463 00100893  // 0x40 addi x0 / add x16 / beq not taken / addi x17
// Branch and jumps, each followed by two wrong-path words
00209663 06300913 06200913 00C009EF  // 0x50 bne taken / flushed / flushed / jal x19
04D00A13 04C00A13 08000A93 000A8B67  // 0x60 flushed / flushed / addi x21 / jalr x22
03700B93 03600B93 00100C93 00100C93  // 0x70 flushed / flushed / never fetched
013B0C33                             // 0x80 add x24 from both link values
// Expected retirements
0100000005 0200000002 0300000003 0400000006 0512345000
0600001014 0712345006 08FFFFFFF0 09FFFFFFFC 0A0000000F
0B00000001 0C00000000 0D00000006 0E12345006 0F1234500B
1000000005 1100000001 1300000060 1500000080 1600000070
18000000D0

// ==== rv_core.f ====
logic/rv_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/register_file.sv
logic/hazard_unit.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/rv_core.sv
verification/tb_clock_gen.sv
verification/rv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := rv_core_tb
FILELIST  := rv_core.f
OBJ_DIR   := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# Binary exits nonzero on $fatal
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
